// ==== cam_array/cam_entry_bank.sv ====
`timescale 1ns/1ps

module cam_entry_bank (
  input  logic          aclk,
  input  logic          areset,
  cam_req_if.bank       req,
  cam_match_if.bank     match_out
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////
  logic [cam_pkg::CAM_SIZE-1:0] hit;                // Combinational compare result
  logic                         stage_en;           // Compare register loads

  assign stage_en = match_out.advance;

  ////////////////////////////////////////////////////////////
  // Entries and compare
  ////////////////////////////////////////////////////////////
  // One word per entry with its own write select, in the manner of a per-entry
  // clock enable. The write group is aligned to LANES so the base is compared
  // against the group start of each entry
  for (genvar i = 0; i < cam_pkg::CAM_SIZE; i++) begin : g_entry
    localparam int LANE       = i % cam_pkg::LANES;               // Lane feeding this entry
    localparam int GROUP_BASE = i - LANE;                         // First entry of its group

    logic [cam_pkg::WORD_WIDTH-1:0] word;                         // Stored value
    logic                           wr_sel;                       // Group is being written

    assign wr_sel = req.wr_en &&
                    (req.wr_base == cam_pkg::INDEX_WIDTH'(GROUP_BASE));

    always_ff @(posedge aclk) begin
      if (wr_sel) begin
        word <= req.wr_data[LANE*cam_pkg::WORD_WIDTH +: cam_pkg::WORD_WIDTH];
      end
    end

    assign hit[i] = ~|(word ^ req.key);             // XOR is zero on equal
  end

  ////////////////////////////////////////////////////////////
  // Compare stage register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      match_out.m_valid <= 1'b0;
    end else if (stage_en) begin
      match_out.m_valid <= req.item_valid;          // Bubble when no item
    end
  end

  // Payload holds with the valid
  always_ff @(posedge aclk) begin
    if (stage_en) begin
      match_out.m_kind <= req.item_kind;
      match_out.match  <= hit;                      // Only meaningful for searches
    end
  end

endmodule

// ==== cam_array/cam_priority_encoder.sv ====
`timescale 1ns/1ps

module cam_priority_encoder (
  input  logic                                aclk,
  input  logic                                areset,
  cam_match_if.enc                            match_in,
  output logic                                advance,
  output logic                                m_tvalid,
  input  logic                                m_tready,
  output logic [cam_pkg::RESULT_WIDTH-1:0]    m_tdata,
  output logic                                m_tuser
);

  localparam int HALF_SIZE = cam_pkg::CAM_SIZE / cam_pkg::HALVES;   // Entries per half

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////
  logic [cam_pkg::INDEX_WIDTH-1:0]   first_idx [cam_pkg::HALVES];   // Lowest hit per half
  logic [cam_pkg::HALVES-1:0]        first_found;                   // Half has a hit

  logic                              s2_valid;                      // Half-search stage
  cam_pkg::item_kind_e               s2_kind;
  logic [cam_pkg::INDEX_WIDTH-1:0]   s2_idx [cam_pkg::HALVES];
  logic [cam_pkg::HALVES-1:0]        s2_found;

  logic [cam_pkg::RESULT_WIDTH-1:0]  merged;                        // Result before output reg

  ////////////////////////////////////////////////////////////
  // Stall
  ////////////////////////////////////////////////////////////
  assign advance          = !m_tvalid || m_tready;  // Output empty or being taken
  assign match_in.advance = advance;

  ////////////////////////////////////////////////////////////
  // Stage 2 first-match search per half
  ////////////////////////////////////////////////////////////
  // Scanning from the top down leaves the lowest set bit
  always_comb begin
    for (int h = 0; h < cam_pkg::HALVES; h++) begin
      first_found[h] = 1'b0;
      first_idx[h]   = '0;
      for (int i = HALF_SIZE - 1; i >= 0; i--) begin
        if (match_in.match[h*HALF_SIZE + i]) begin
          first_found[h] = 1'b1;
          first_idx[h]   = cam_pkg::INDEX_WIDTH'(h*HALF_SIZE + i);
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      s2_valid <= 1'b0;
    end else if (advance) begin
      s2_valid <= match_in.m_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (advance) begin
      s2_kind  <= match_in.m_kind;
      s2_found <= first_found;
      s2_idx   <= first_idx;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 3 merge and output register
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (s2_kind == cam_pkg::item_load_done) begin
      merged = cam_pkg::UPDATE_DONE_CODE;           // Done overrides any match
    end else begin
      merged = cam_pkg::MISS_CODE;
      for (int h = cam_pkg::HALVES - 1; h >= 0; h--) begin
        if (s2_found[h]) begin
          merged = cam_pkg::RESULT_WIDTH'(s2_idx[h]);   // Lower half wins
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      m_tvalid <= 1'b0;
    end else if (advance) begin
      m_tvalid <= s2_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (advance) begin
      m_tdata <= merged;
      m_tuser <= (s2_kind == cam_pkg::item_load_done);
    end
  end

endmodule

// ==== common/cam_match_if.sv ====
`timescale 1ns/1ps

interface cam_match_if;

  logic                              m_valid;         // Compare stage holds an item
  cam_pkg::item_kind_e               m_kind;          // Kind of that item
  logic [cam_pkg::CAM_SIZE-1:0]      match;           // Bit set when entry equals key

  logic                              advance;         // Downstream accepts a new item

  modport bank (
    output m_valid,
    output m_kind,
    output match,
    input  advance
  );

  modport enc (
    input  m_valid,
    input  m_kind,
    input  match,
    output advance
  );

endinterface

// ==== common/cam_pkg.sv ====
package cam_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////
  localparam int CAM_SIZE     = 256;                  // Number of stored entries
  localparam int LANES        = 16;                   // Entries written per update beat
  localparam int WORD_WIDTH   = 32;                   // Entry and key width
  localparam int DATA_WIDTH   = LANES * WORD_WIDTH;   // Input beat width
  localparam int INDEX_WIDTH  = $clog2(CAM_SIZE);     // Entry index width
  localparam int RESULT_WIDTH = 16;                   // Output result width
  localparam int HALVES       = 2;                    // Independent first-match searches

  ////////////////////////////////////////////////////////////
  // Result codes
  ////////////////////////////////////////////////////////////
  // No match, all ones over INDEX_WIDTH+1 bits
  localparam logic [RESULT_WIDTH-1:0] MISS_CODE =
    RESULT_WIDTH'({(INDEX_WIDTH + 1){1'b1}});
  localparam logic [RESULT_WIDTH-1:0] UPDATE_DONE_CODE =
    RESULT_WIDTH'(100);                               // Full table loaded

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    op_idle       = 2'd0,                             // Beat is dropped
    op_update_all = 2'd1,                             // Beat writes LANES entries
    op_search     = 2'd2                              // Lane 0 is the search key
  } cam_op_e;

  typedef enum logic {
    item_search    = 1'b0,                            // Result is a match index
    item_load_done = 1'b1                             // Result is the done code
  } item_kind_e;

endpackage

// ==== common/cam_req_if.sv ====
`timescale 1ns/1ps

interface cam_req_if;

  // Entry write port, one aligned group of LANES words
  logic                                wr_en;         // Qualified update beat
  logic [cam_pkg::INDEX_WIDTH-1:0]     wr_base;       // First entry of the group
  logic [cam_pkg::DATA_WIDTH-1:0]      wr_data;       // Lane n goes to wr_base+n

  // Pipeline item toward the compare stage
  logic                                item_valid;    // Qualified search or done item
  cam_pkg::item_kind_e                 item_kind;     // Search or load done
  logic [cam_pkg::WORD_WIDTH-1:0]      key;           // Search key

  logic                                advance;       // Pipeline moves this cycle

  modport ctrl (
    output wr_en, wr_base, wr_data,
    output item_valid, item_kind, key,
    input  advance
  );

  modport bank (
    input wr_en, wr_base, wr_data,
    input item_valid, item_kind, key,
    input advance
  );

endinterface

// ==== hdl/cam_cmd_ctrl.sv ====
`timescale 1ns/1ps

module cam_cmd_ctrl (
  input  logic                              aclk,
  input  logic                              areset,
  input  logic                              s_tvalid,
  output logic                              s_tready,
  input  logic [cam_pkg::DATA_WIDTH-1:0]    s_tdata,
  input  cam_pkg::cam_op_e                  s_op,
  cam_req_if.ctrl                           req
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////
  logic                              accept;        // Beat transfers this edge
  logic                              is_update;     // Decoded update-all
  logic                              is_search;     // Decoded search
  logic                              last_group;    // Pointer sits on the final group
  logic [cam_pkg::INDEX_WIDTH-1:0]   wr_ptr;        // Base of next group to write

  ////////////////////////////////////////////////////////////
  // Opcode decode and acceptance
  ////////////////////////////////////////////////////////////
  always_comb begin
    is_update = 1'b0;
    is_search = 1'b0;
    case (s_op)
      cam_pkg::op_update_all: is_update = 1'b1;
      cam_pkg::op_search:     is_search = 1'b1;
      default: begin                                // Idle and unused codes
        is_update = 1'b0;
        is_search = 1'b0;
      end
    endcase
  end

  assign s_tready = req.advance;                    // Ready whenever the pipe moves
  assign accept   = s_tvalid && req.advance;        // Idle beats are taken and dropped

  assign last_group = (wr_ptr == cam_pkg::INDEX_WIDTH'(cam_pkg::CAM_SIZE - cam_pkg::LANES));

  ////////////////////////////////////////////////////////////
  // Entry write request
  ////////////////////////////////////////////////////////////
  assign req.wr_en   = accept && is_update;
  assign req.wr_base = wr_ptr;
  assign req.wr_data = s_tdata;                     // All lanes go to the bank

  ////////////////////////////////////////////////////////////
  // Pipeline item
  ////////////////////////////////////////////////////////////
  // A search always makes an item, an update only on the wrap beat
  assign req.item_valid = accept && (is_search || (is_update && last_group));
  assign req.item_kind  = is_update ? cam_pkg::item_load_done : cam_pkg::item_search;
  assign req.key        = s_tdata[cam_pkg::WORD_WIDTH-1:0];   // Lane 0

  ////////////////////////////////////////////////////////////
  // Write pointer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
    end else if (req.wr_en) begin
      if (last_group) begin
        wr_ptr <= '0;                               // Table full, start over
      end else begin
        wr_ptr <= wr_ptr + cam_pkg::INDEX_WIDTH'(cam_pkg::LANES);
      end
    end
  end

endmodule

// ==== hdl/cam_top.sv ====
`timescale 1ns/1ps

module cam_top (
  input  logic                                aclk,
  input  logic                                areset,

  // Command stream in
  input  logic                                s_tvalid,
  output logic                                s_tready,
  input  logic [cam_pkg::DATA_WIDTH-1:0]      s_tdata,
  input  cam_pkg::cam_op_e                    s_op,       // Travels with the beat

  // Result stream out
  output logic                                m_tvalid,
  input  logic                                m_tready,
  output logic [cam_pkg::RESULT_WIDTH-1:0]    m_tdata,
  output logic                                m_tuser     // High on load done
);

  ////////////////////////////////////////////////////////////
  // Internal buses
  ////////////////////////////////////////////////////////////
  cam_req_if   req_bus ();                                // Ctrl to bank
  cam_match_if match_bus ();                              // Bank to encoder

  ////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////
  cam_cmd_ctrl u_cmd_ctrl (
    .aclk     (aclk),
    .areset   (areset),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .s_op     (s_op),
    .req      (req_bus.ctrl)
  );

  cam_entry_bank u_entry_bank (
    .aclk      (aclk),
    .areset    (areset),
    .req       (req_bus.bank),
    .match_out (match_bus.bank)
  );

  // The stall signal of the encoder also feeds the request side
  cam_priority_encoder u_prio_enc (
    .aclk     (aclk),
    .areset   (areset),
    .match_in (match_bus.enc),
    .advance  (req_bus.advance),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tdata  (m_tdata),
    .m_tuser  (m_tuser)
  );

endmodule

// ==== sources.f ====
+incdir+verification
common/cam_pkg.sv
common/cam_req_if.sv
common/cam_match_if.sv
hdl/cam_cmd_ctrl.sv
cam_array/cam_entry_bank.sv
cam_array/cam_priority_encoder.sv
hdl/cam_top.sv
verification/cam_tb.sv

// ==== verification/cam_model.svh ====
`ifndef CAM_MODEL_SVH
`define CAM_MODEL_SVH

////////////////////////////////////////////////////////////
// Reference model state
////////////////////////////////////////////////////////////
logic [cam_pkg::WORD_WIDTH-1:0]   model_entries [cam_pkg::CAM_SIZE];  // Mirror of the table
bit                               model_written [cam_pkg::CAM_SIZE];  // Entry loaded once
int                               model_ptr;                          // Next group base
logic [cam_pkg::RESULT_WIDTH-1:0] exp_result [$];                     // Expected m_tdata
bit                               exp_user [$];                       // Expected m_tuser
int                               exp_tag [$];                        // Test owning the response

task automatic model_reset();
  model_ptr = 0;
  exp_result.delete();
  exp_user.delete();
  exp_tag.delete();
  for (int i = 0; i < cam_pkg::CAM_SIZE; i++) begin
    model_written[i] = 1'b0;                        // Entries start unknown
  end
endtask

// Lowest index holding the key, scanned in plain order
function automatic logic [cam_pkg::RESULT_WIDTH-1:0] model_search(
  input logic [cam_pkg::WORD_WIDTH-1:0] key
);
  for (int i = 0; i < cam_pkg::CAM_SIZE; i++) begin
    if (model_written[i] && (model_entries[i] == key)) begin
      return cam_pkg::RESULT_WIDTH'(i);
    end
  end
  return cam_pkg::MISS_CODE;
endfunction

function automatic bit model_has_key(input logic [cam_pkg::WORD_WIDTH-1:0] key);
  return model_search(key) != cam_pkg::MISS_CODE;
endfunction

// Called once per accepted beat, at the accept edge
task automatic model_accept(
  input cam_pkg::cam_op_e               op,
  input logic [cam_pkg::DATA_WIDTH-1:0] data,
  input int                             tag
);
  case (op)
    cam_pkg::op_update_all: begin
      for (int lane = 0; lane < cam_pkg::LANES; lane++) begin
        model_entries[model_ptr + lane] = data[lane*cam_pkg::WORD_WIDTH +: cam_pkg::WORD_WIDTH];
        model_written[model_ptr + lane] = 1'b1;
      end
      if (model_ptr == cam_pkg::CAM_SIZE - cam_pkg::LANES) begin
        exp_result.push_back(cam_pkg::UPDATE_DONE_CODE);    // Wrap beat reports done
        exp_user.push_back(1'b1);
        exp_tag.push_back(tag);
        model_ptr = 0;
      end else begin
        model_ptr = model_ptr + cam_pkg::LANES;
      end
    end
    cam_pkg::op_search: begin
      exp_result.push_back(model_search(data[cam_pkg::WORD_WIDTH-1:0]));
      exp_user.push_back(1'b0);
      exp_tag.push_back(tag);
    end
    default: begin
    end                                             // Idle beat is dropped
  endcase
endtask

`endif

// ==== verification/cam_tb.sv ====
`timescale 1ns/1ps

module cam_tb;

  localparam int WAIT_LIMIT = 200;                  // Cycles before a wait gives up

  logic                                aclk = 1'b0;
  logic                                areset;
  logic                                s_tvalid;
  logic                                s_tready;
  logic [cam_pkg::DATA_WIDTH-1:0]      s_tdata;
  cam_pkg::cam_op_e                    s_op;
  logic                                m_tvalid;
  logic                                m_tready;
  logic [cam_pkg::RESULT_WIDTH-1:0]    m_tdata;
  logic                                m_tuser;

  integer                              seed;           // Shared $random state
  logic [cam_pkg::WORD_WIDTH-1:0]      dup_words [4];  // Words stored at many indices
  int                                  cur_tag;        // Test of the beat on the bus
  int                                  accept_count;   // Accepted beats so far
  bit                                  bp_enable;      // Random m_tready when set
  bit                                  ready_low;      // Sink stalled around reset
  bit                                  timed_out;
  int                                  value_errors;
  int                                  other_errors;
  int                                  timeout_count;

  `include "cam_model.svh"

  cam_top UUT (
    .aclk     (aclk),
    .areset   (areset),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .s_op     (s_op),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tdata  (m_tdata),
    .m_tuser  (m_tuser)
  );

  always #20 aclk = ~aclk;                          // 40 ns period

  always @(negedge aclk) begin
    if (ready_low) begin
      m_tready = 1'b0;                              // s_tready then comes from an empty output
    end else if (bp_enable) begin
      m_tready = $random(seed) & 1;                 // About half the cycles stall
    end else begin
      m_tready = 1'b1;
    end
  end

  function automatic string test_name(input int tag);
    case (tag)
      0:       return "reset";
      1:       return "full_load";
      2:       return "search_hit";
      3:       return "search_miss";
      4:       return "back_pressure";
      default: return "partial_reload";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Monitor and checks
  ////////////////////////////////////////////////////////////
  task automatic check_response();
    logic [cam_pkg::RESULT_WIDTH-1:0] exp_d;
    bit                               exp_u;
    int                               tag;
    assert (exp_result.size() != 0) else begin
      other_errors++;
      $display("Response %h arrived with no request outstanding", m_tdata);
    end
    if (exp_result.size() != 0) begin
      exp_d = exp_result.pop_front();
      exp_u = exp_user.pop_front();
      tag   = exp_tag.pop_front();
      assert ((m_tdata === exp_d) && (m_tuser === exp_u)) else begin
        value_errors++;
        $display("[FAIL] %s expected %h user %b actual %h user %b",
                 test_name(tag), exp_d, exp_u, m_tdata, m_tuser);
      end
    end
  endtask

  // Pre-edge values are sampled with outputs first since they belong to older beats
  always @(posedge aclk) begin
    if (!areset) begin
      if (m_tvalid && m_tready) check_response();
      if (s_tvalid && s_tready) begin
        model_accept(s_op, s_tdata, cur_tag);
        accept_count++;
      end
    end
  end

  task automatic check_idle_state(input string phase);
    assert (m_tvalid === 1'b0) else begin
      value_errors++;
      $display("[FAIL] %s m_tvalid expected 0 actual %b", phase, m_tvalid);
    end
    assert (s_tready === 1'b1) else begin
      value_errors++;
      $display("[FAIL] %s s_tready expected 1 actual %b", phase, s_tready);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  // Starts and ends on a falling edge with valid held until the beat is taken
  task automatic drive_beat(
    input cam_pkg::cam_op_e op, input logic [cam_pkg::DATA_WIDTH-1:0] data, input int tag
  );
    int start_count;
    int waited;
    if (timed_out) return;
    s_tvalid    = 1'b1;
    s_op        = op;
    s_tdata     = data;
    cur_tag     = tag;
    start_count = accept_count;
    waited      = 0;
    while ((accept_count == start_count) && (waited < WAIT_LIMIT)) begin
      @(negedge aclk);
      waited++;
    end
    s_tvalid = 1'b0;
    if (accept_count == start_count) begin
      timed_out = 1'b1;
      timeout_count++;
      $display("Timed out waiting for a beat to be accepted in %s", test_name(tag));
    end
  endtask

  task automatic make_random_beat(output logic [cam_pkg::DATA_WIDTH-1:0] data);
    for (int lane = 0; lane < cam_pkg::LANES; lane++) begin
      data[lane*cam_pkg::WORD_WIDTH +: cam_pkg::WORD_WIDTH] = $random(seed);
    end
  endtask

  task automatic make_load_beat(output logic [cam_pkg::DATA_WIDTH-1:0] data);
    make_random_beat(data);
    for (int lane = 0; lane < cam_pkg::LANES; lane++) begin
      if (($random(seed) & 7) == 0) begin             // Seed duplicates across the table
        data[lane*cam_pkg::WORD_WIDTH +: cam_pkg::WORD_WIDTH] =
          dup_words[$unsigned($random(seed)) % 4];
      end
    end
  endtask

  task automatic drive_load(input int tag);
    logic [cam_pkg::DATA_WIDTH-1:0] data;
    make_load_beat(data);
    drive_beat(cam_pkg::op_update_all, data, tag);
  endtask

  task automatic drive_hit(input bit upper, input int tag);
    int                             idx;
    logic [cam_pkg::DATA_WIDTH-1:0] data;
    idx = $unsigned($random(seed)) % (cam_pkg::CAM_SIZE / 2);
    if (upper) idx = idx + cam_pkg::CAM_SIZE / 2;   // Key taken from the upper half
    make_random_beat(data);                         // Upper lanes are noise
    data[cam_pkg::WORD_WIDTH-1:0] = model_entries[idx];
    drive_beat(cam_pkg::op_search, data, tag);
  endtask

  task automatic drive_miss(input int tag);
    logic [cam_pkg::DATA_WIDTH-1:0] data;
    make_random_beat(data);
    while (model_has_key(data[cam_pkg::WORD_WIDTH-1:0])) begin
      data[cam_pkg::WORD_WIDTH-1:0] = $random(seed);
    end
    drive_beat(cam_pkg::op_search, data, tag);
  endtask

  task automatic idle_gap();
    int n;
    n = $unsigned($random(seed)) % 3;
    repeat (n) @(negedge aclk);
  endtask

  task automatic wait_drain();
    int waited;
    if (timed_out) return;
    waited = 0;
    while ((exp_result.size() != 0) && (waited < WAIT_LIMIT)) begin
      @(negedge aclk);
      waited++;
    end
    if (exp_result.size() != 0) begin
      timed_out = 1'b1;
      timeout_count++;
      $display("Timed out waiting for %0d outstanding responses", exp_result.size());
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [cam_pkg::DATA_WIDTH-1:0] data;
    int                             pick;
    seed          = 32'hdee6;
    areset        = 1'b1;
    s_tvalid      = 1'b0;
    s_tdata       = '0;
    s_op          = cam_pkg::op_idle;
    m_tready      = 1'b0;
    ready_low     = 1'b1;
    bp_enable     = 1'b0;
    timed_out     = 1'b0;
    cur_tag       = 0;
    accept_count  = 0;
    value_errors  = 0;
    other_errors  = 0;
    timeout_count = 0;
    model_reset();
    for (int i = 0; i < 4; i++) dup_words[i] = $random(seed);

    for (int i = 0; i < 16; i++) begin
      @(negedge aclk);
      check_idle_state("reset");
    end
    areset = 1'b0;
    for (int i = 0; i < 3; i++) begin
      @(negedge aclk);
      check_idle_state("after_reset");
    end
    ready_low = 1'b0;

    for (int g = 0; g < cam_pkg::CAM_SIZE / cam_pkg::LANES; g++) drive_load(1);
    wait_drain();                                   // Done response must have come back

    for (int n = 0; n < 40; n++) drive_hit(n[0], 2);
    for (int n = 0; n < 12; n++) drive_miss(3);
    wait_drain();

    bp_enable = 1'b1;
    for (int n = 0; n < 80; n++) begin
      pick = $unsigned($random(seed)) % 8;
      case (pick)
        0, 1: begin
          make_random_beat(data);
          drive_beat(cam_pkg::op_idle, data, 4);    // No response expected
        end
        2:       drive_miss(4);
        3:       drive_load(4);
        default: drive_hit(pick[0], 4);
      endcase
      idle_gap();
    end

    // Second pass over the table with searches between the groups
    for (int g = 0; g < cam_pkg::CAM_SIZE / cam_pkg::LANES; g++) begin
      drive_load(5);
      drive_hit(1'b0, 5);
      drive_hit(1'b1, 5);
      idle_gap();
    end

    bp_enable = 1'b0;
    wait_drain();
    repeat (20) @(negedge aclk);                    // Catch stray extra responses

    $display("Errors: %0d value, %0d other, %0d timeout",
             value_errors, other_errors, timeout_count);
    if ((value_errors == 0) && (other_errors == 0) && (timeout_count == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
